// File: logic/cbm2_io_params.svh
`ifndef CBM2_IO_PARAMS_SVH
`define CBM2_IO_PARAMS_SVH

// ==============================
// Triport bank and address map
// ==============================

// Number of triport devices on the shared bus
`define CBM2_TPI_COUNT 2
// Host address width
`define CBM2_ADDR_W 8
// First device, each device takes eight register bytes
`define CBM2_TPI_BASE 8'h40
`define CBM2_TPI_STRIDE 8

// ==============================
// System frame
// ==============================

// Frames between refresh pulses
`define CBM2_RFSH_FRAMES 8
// Byte returned for anything that is not decoded
`define CBM2_OPEN_BUS 8'hFF

`endif

// File: logic/cbm2_io_pkg.sv
`default_nettype none

package cbm2_io_pkg;

   // 16-slot Professional frame
   // CPU slots sit in the middle, video slots close the frame
   typedef enum logic [3:0] {
      EXT0, EXT1, EXT2, EXT3,
      CPU0, CPU1, CPU2, CPU3,
      EXT4, EXT5, EXT6, EXT7,
      VID0, VID1, VID2, VID3
   } sys_cycle_t;

   // 6525 register selects
   // Interrupt mode registers are not present, 6 and 7 read open bus
   typedef enum logic [2:0] {
      PRA, PRB, PRC,
      DDRA, DDRB, DDRC,
      RSV6, RSV7
   } tpi_reg_t;

   // Data bus byte
   typedef logic [7:0] data_t;

endpackage

`default_nettype wire

// File: logic/io_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

interface io_bus_if;

   // One-hot device select, zero for unmapped addresses
   logic [`CBM2_TPI_COUNT-1:0] sel;
   // Register select within the device
   cbm2_io_pkg::tpi_reg_t rs;
   // Write flag, low for reads
   logic we;
   cbm2_io_pkg::data_t wdata;
   // Single cycle access pulse
   logic strobe;

   // Bridge owns the bus
   modport bridge (output sel, rs, we, wdata, strobe);

   // Devices see everything
   modport device (input sel, rs, we, wdata, strobe);

   // Collector only needs to know who was read and when
   modport collector (input sel, we, strobe);

endinterface

`default_nettype wire

// File: logic/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module cycle_sequencer (
   input  wire  clk_sys,
   input  wire  reset,
   input  wire  pause_i,
   output logic io_strobe_o,
   output logic refresh_o,
   output logic pause_o
);

   localparam int FRAME_W = $clog2(`CBM2_RFSH_FRAMES);
   localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`CBM2_RFSH_FRAMES - 1);

   cbm2_io_pkg::sys_cycle_t slot;
   logic [FRAME_W-1:0]      frame_cnt;
   logic                    sys_enable;
   logic                    frame_wrap;

   // Last slot of the frame
   assign frame_wrap = (slot == cbm2_io_pkg::VID3);

   // ==============================
   // Slot and frame counters
   // ==============================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         slot       <= cbm2_io_pkg::EXT0;
         frame_cnt  <= '0;
         sys_enable <= 1'b0;
         refresh_o  <= 1'b0;
      end else begin
         refresh_o <= 1'b0;
         if (frame_wrap) begin
            slot      <= cbm2_io_pkg::EXT0;
            frame_cnt <= (frame_cnt == FRAME_LAST) ? '0 : frame_cnt + 1'b1;
            // Refresh frame, the only point where pause is looked at
            if (frame_cnt == '0) begin
               refresh_o  <= 1'b1;
               sys_enable <= ~pause_i;
            end
         end else begin
            slot <= cbm2_io_pkg::sys_cycle_t'(slot + 4'd1);
         end
      end
   end

   // CPU slot of a running frame
   assign io_strobe_o = sys_enable && (slot == cbm2_io_pkg::CPU3);
   assign pause_o     = ~sys_enable;

   // Refresh only comes out of the wrap that closes frame zero
   a_refresh_at_wrap : assert property (
      @(posedge clk_sys) disable iff (reset)
      refresh_o |-> ($past(slot) == cbm2_io_pkg::VID3) && ($past(frame_cnt) == '0)
   );

endmodule

`default_nettype wire

// File: logic/host_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module host_bus_bridge (
   input  wire                      clk_sys,
   input  wire                      reset,
   input  wire                      req_i,
   input  wire                      we_i,
   input  wire [`CBM2_ADDR_W-1:0]   addr_i,
   input  wire cbm2_io_pkg::data_t  wdata_i,
   input  wire                      io_strobe_i,
   input  wire cbm2_io_pkg::data_t  rd_byte_i,
   output logic                     ack_o,
   output cbm2_io_pkg::data_t       rdata_o,
   io_bus_if.bridge                 bus
);

   localparam logic [`CBM2_ADDR_W-1:0] TPI_BASE   = `CBM2_TPI_BASE;
   localparam logic [`CBM2_ADDR_W-1:0] TPI_STRIDE = `CBM2_ADDR_W'(`CBM2_TPI_STRIDE);
   localparam logic [`CBM2_ADDR_W-1:0] TPI_COUNT  = `CBM2_ADDR_W'(`CBM2_TPI_COUNT);

   typedef enum logic [1:0] {
      IDLE, WAIT_SLOT, ACK, RELEASE
   } state_t;

   state_t                     state;
   logic [`CBM2_ADDR_W-1:0]    addr_off;
   logic [`CBM2_ADDR_W-1:0]    dev_idx;
   logic                       in_map;
   logic [`CBM2_TPI_COUNT-1:0] sel_dec;
   logic [`CBM2_TPI_COUNT-1:0] sel_q;
   logic                       we_q;
   cbm2_io_pkg::tpi_reg_t      rs_q;
   cbm2_io_pkg::data_t         wdata_q;

   // ==============================
   // Address decode
   // ==============================

   assign addr_off = addr_i - TPI_BASE;
   assign dev_idx  = addr_off / TPI_STRIDE;
   // Below the base the offset wraps, so check both ends
   assign in_map   = (addr_i >= TPI_BASE) && (dev_idx < TPI_COUNT);

   always_comb begin
      for (int i = 0; i < `CBM2_TPI_COUNT; i++) begin
         sel_dec[i] = in_map && (dev_idx == `CBM2_ADDR_W'(i));
      end
   end

   // ==============================
   // Four-phase handshake
   // ==============================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         state <= IDLE;
         sel_q <= '0;
         we_q  <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (req_i) begin
                  state <= WAIT_SLOT;
                  sel_q <= sel_dec;
                  we_q  <= we_i;
               end
            end
            // Hold until the sequencer grants the CPU slot
            WAIT_SLOT: if (io_strobe_i) state <= ACK;
            // Back-pressure, no new access while req is still up
            ACK:       if (!req_i) state <= RELEASE;
            RELEASE:   state <= IDLE;
            default:   state <= IDLE;
         endcase
      end
   end

   // Register select and write data ride along with the select
   always_ff @(posedge clk_sys) begin
      if (state == IDLE && req_i) begin
         rs_q    <= cbm2_io_pkg::tpi_reg_t'(addr_off[2:0]);
         wdata_q <= wdata_i;
      end
   end

   assign bus.sel    = sel_q;
   assign bus.rs     = rs_q;
   assign bus.we     = we_q;
   assign bus.wdata  = wdata_q;
   assign bus.strobe = (state == WAIT_SLOT) && io_strobe_i;

   // Collector has the byte registered by the time ack is up
   assign ack_o   = (state == ACK);
   assign rdata_o = rd_byte_i;

   a_sel_onehot : assert property (
      @(posedge clk_sys) disable iff (reset) $onehot0(bus.sel)
   );

   a_ack_needs_req : assert property (
      @(posedge clk_sys) disable iff (reset) $rose(ack_o) |-> req_i
   );

endmodule

`default_nettype wire

// File: logic/triport_device.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module triport_device #(
   parameter int DEV_INDEX = 0
) (
   input  wire                     clk_sys,
   input  wire                     reset,
   input  wire cbm2_io_pkg::data_t pa_i,
   input  wire cbm2_io_pkg::data_t pb_i,
   input  wire cbm2_io_pkg::data_t pc_i,
   output cbm2_io_pkg::data_t      pa_o,
   output cbm2_io_pkg::data_t      pb_o,
   output cbm2_io_pkg::data_t      pc_o,
   output cbm2_io_pkg::data_t      rdata_o,
   io_bus_if.device                bus
);

   cbm2_io_pkg::data_t pra;
   cbm2_io_pkg::data_t prb;
   cbm2_io_pkg::data_t prc;
   cbm2_io_pkg::data_t ddra;
   cbm2_io_pkg::data_t ddrb;
   cbm2_io_pkg::data_t ddrc;
   logic               wr_en;

   // This device is addressed for a write
   assign wr_en = bus.strobe && bus.we && bus.sel[DEV_INDEX];

   // ==============================
   // Port and direction registers
   // ==============================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pra  <= '0;
         prb  <= '0;
         prc  <= '0;
         ddra <= '0;
         ddrb <= '0;
         ddrc <= '0;
      end else if (wr_en) begin
         case (bus.rs)
            cbm2_io_pkg::PRA:  pra  <= bus.wdata;
            cbm2_io_pkg::PRB:  prb  <= bus.wdata;
            cbm2_io_pkg::PRC:  prc  <= bus.wdata;
            cbm2_io_pkg::DDRA: ddra <= bus.wdata;
            cbm2_io_pkg::DDRB: ddrb <= bus.wdata;
            cbm2_io_pkg::DDRC: ddrc <= bus.wdata;
            // RSV6 and RSV7 swallow the write
            default: ;
         endcase
      end
   end

   // Open collector, input bits float high
   assign pa_o = pra | ~ddra;
   assign pb_o = prb | ~ddrb;
   assign pc_o = prc | ~ddrc;

   // ==============================
   // Read mux
   // ==============================

   // Port reads see the wired-AND of our driver and the outside world
   always_comb begin
      case (bus.rs)
         cbm2_io_pkg::PRA:  rdata_o = pa_o & pa_i;
         cbm2_io_pkg::PRB:  rdata_o = pb_o & pb_i;
         cbm2_io_pkg::PRC:  rdata_o = pc_o & pc_i;
         cbm2_io_pkg::DDRA: rdata_o = ddra;
         cbm2_io_pkg::DDRB: rdata_o = ddrb;
         cbm2_io_pkg::DDRC: rdata_o = ddrc;
         default:           rdata_o = `CBM2_OPEN_BUS;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/read_data_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module read_data_collector (
   input  wire                     clk_sys,
   input  wire                     reset,
   input  wire cbm2_io_pkg::data_t dev_rdata_i [`CBM2_TPI_COUNT],
   output cbm2_io_pkg::data_t      rd_byte_o,
   io_bus_if.collector             bus
);

   cbm2_io_pkg::data_t rd_pick;

   // Select is one-hot, an empty select leaves the open bus value
   always_comb begin
      rd_pick = `CBM2_OPEN_BUS;
      for (int i = 0; i < `CBM2_TPI_COUNT; i++) begin
         if (bus.sel[i]) begin
            rd_pick = dev_rdata_i[i];
         end
      end
   end

   // ==============================
   // Read byte register
   // ==============================

   // Only reads update it, writes leave the last byte in place
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         rd_byte_o <= '0;
      end else if (bus.strobe && !bus.we) begin
         rd_byte_o <= rd_pick;
      end
   end

endmodule

`default_nettype wire

// File: logic/cbm2_io_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module cbm2_io_top (
   input  wire                             clk_sys,
   input  wire                             reset,
   input  wire                             pause_i,
   input  wire                             req_i,
   input  wire                             we_i,
   input  wire [`CBM2_ADDR_W-1:0]          addr_i,
   input  wire [7:0]                       wdata_i,
   input  wire [`CBM2_TPI_COUNT-1:0][7:0]  pa_i,
   input  wire [`CBM2_TPI_COUNT-1:0][7:0]  pb_i,
   input  wire [`CBM2_TPI_COUNT-1:0][7:0]  pc_i,
   output wire                             ack_o,
   output wire [7:0]                       rdata_o,
   output wire                             refresh_o,
   output wire                             pause_o,
   output wire [`CBM2_TPI_COUNT-1:0][7:0]  pa_o,
   output wire [`CBM2_TPI_COUNT-1:0][7:0]  pb_o,
   output wire [`CBM2_TPI_COUNT-1:0][7:0]  pc_o
);

   wire                     io_strobe;
   wire cbm2_io_pkg::data_t rd_byte;
   wire cbm2_io_pkg::data_t dev_rdata [`CBM2_TPI_COUNT];

   io_bus_if bus_if ();

   // ==============================
   // Frame timing and host side
   // ==============================

   cycle_sequencer sequencer_i (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .pause_i     (pause_i),
      .io_strobe_o (io_strobe),
      .refresh_o   (refresh_o),
      .pause_o     (pause_o)
   );

   host_bus_bridge bridge_i (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .req_i       (req_i),
      .we_i        (we_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .io_strobe_i (io_strobe),
      .rd_byte_i   (rd_byte),
      .ack_o       (ack_o),
      .rdata_o     (rdata_o),
      .bus         (bus_if.bridge)
   );

   // ==============================
   // Triport bank
   // ==============================

   for (genvar g = 0; g < `CBM2_TPI_COUNT; g++) begin : g_tpi
      triport_device #(
         .DEV_INDEX (g)
      ) tpi_i (
         .clk_sys (clk_sys),
         .reset   (reset),
         .pa_i    (pa_i[g]),
         .pb_i    (pb_i[g]),
         .pc_i    (pc_i[g]),
         .pa_o    (pa_o[g]),
         .pb_o    (pb_o[g]),
         .pc_o    (pc_o[g]),
         .rdata_o (dev_rdata[g]),
         .bus     (bus_if.device)
      );
   end

   read_data_collector collector_i (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .dev_rdata_i (dev_rdata),
      .rd_byte_o   (rd_byte),
      .bus         (bus_if.collector)
   );

endmodule

`default_nettype wire

// File: tb/cbm2_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cbm2_io_params.svh"

module cbm2_io_tb;

   localparam int NDEV = `CBM2_TPI_COUNT;

   logic                     clk_sys;
   logic                     reset;
   logic                     pause_i;
   logic                     req_i;
   logic                     we_i;
   logic [`CBM2_ADDR_W-1:0]  addr_i;
   logic [7:0]               wdata_i;
   logic [NDEV-1:0][7:0]     pa_in;
   logic [NDEV-1:0][7:0]     pb_in;
   logic [NDEV-1:0][7:0]     pc_in;
   wire                      ack_o;
   wire  [7:0]               rdata_o;
   wire                      refresh_o;
   wire                      pause_o;
   wire  [NDEV-1:0][7:0]     pa_o;
   wire  [NDEV-1:0][7:0]     pb_o;
   wire  [NDEV-1:0][7:0]     pc_o;

   // Reference register file with port index 0..2 for A..C
   logic [7:0]           m_port [NDEV][3];
   logic [7:0]           m_dir  [NDEV][3];
   logic [NDEV-1:0][7:0] exp_pa;
   logic [NDEV-1:0][7:0] exp_pb;
   logic [NDEV-1:0][7:0] exp_pc;
   logic [7:0]           exp_rdata;
   // High from request start until the model has caught up
   logic                 busy;
   int                   rfsh_gap;
   logic                 rfsh_seen;

   cbm2_io_top dut_i (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .pause_i   (pause_i),
      .req_i     (req_i),
      .we_i      (we_i),
      .addr_i    (addr_i),
      .wdata_i   (wdata_i),
      .pa_i      (pa_in),
      .pb_i      (pb_in),
      .pc_i      (pc_in),
      .ack_o     (ack_o),
      .rdata_o   (rdata_o),
      .refresh_o (refresh_o),
      .pause_o   (pause_o),
      .pa_o      (pa_o),
      .pb_o      (pb_o),
      .pc_o      (pc_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #50 clk_sys = ~clk_sys;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   // ==============================
   // Register model
   // ==============================

   // Direction 1 drives the port bit and direction 0 leaves the pin pulled high
   function automatic logic [7:0] pin_level(input logic [7:0] port, input logic [7:0] dir);
      return (port & dir) | ~dir;
   endfunction

   function automatic logic [7:0] pin_input(input int dev, input int port);
      case (port)
         0:       return pa_in[dev];
         1:       return pb_in[dev];
         default: return pc_in[dev];
      endcase
   endfunction

   function automatic logic [7:0] reg_addr(input int dev, input int rsel);
      return 8'(`CBM2_TPI_BASE + dev * `CBM2_TPI_STRIDE + rsel);
   endfunction

   // Selects 0..2 are ports, 3..5 directions, 6 and 7 open bus
   function automatic logic [7:0] expected_read(input logic [7:0] addr);
      int off;
      int dev;
      int rsel;
      off  = int'(addr) - int'(`CBM2_TPI_BASE);
      dev  = off / `CBM2_TPI_STRIDE;
      rsel = off % `CBM2_TPI_STRIDE;
      if (off < 0 || dev >= NDEV || rsel >= 6) return `CBM2_OPEN_BUS;
      if (rsel >= 3) return m_dir[dev][rsel-3];
      return pin_level(m_port[dev][rsel], m_dir[dev][rsel]) & pin_input(dev, rsel);
   endfunction

   function automatic void apply_write(input logic [7:0] addr, input logic [7:0] data);
      int off;
      int dev;
      int rsel;
      off  = int'(addr) - int'(`CBM2_TPI_BASE);
      dev  = off / `CBM2_TPI_STRIDE;
      rsel = off % `CBM2_TPI_STRIDE;
      if (off < 0 || dev >= NDEV || rsel >= 6) return;
      if (rsel >= 3) m_dir[dev][rsel-3] = data;
      else m_port[dev][rsel] = data;
   endfunction

   always_comb begin
      for (int dv = 0; dv < NDEV; dv++) begin
         exp_pa[dv] = pin_level(m_port[dv][0], m_dir[dv][0]);
         exp_pb[dv] = pin_level(m_port[dv][1], m_dir[dv][1]);
         exp_pc[dv] = pin_level(m_port[dv][2], m_dir[dv][2]);
      end
   end

   // Cycles since the last refresh pulse
   always @(posedge clk_sys) begin
      if (reset) begin
         rfsh_gap  <= 0;
         rfsh_seen <= 1'b0;
      end else if (refresh_o) begin
         rfsh_gap  <= 1;
         rfsh_seen <= 1'b1;
      end else begin
         rfsh_gap <= rfsh_gap + 1;
      end
   end

   // ==============================
   // Checking
   // ==============================

   a_reset_state : assert property (@(posedge clk_sys)
      reset |=> !ack_o && !refresh_o && pause_o)
      else abort_run($sformatf("error at %0t: outputs not at reset values", $time));

   a_pins : assert property (@(posedge clk_sys) disable iff (reset)
      !busy |-> (pa_o == exp_pa) && (pb_o == exp_pb) && (pc_o == exp_pc))
      else abort_run($sformatf("error at %0t: pins %h %h %h, expected %h %h %h", $time,
         $sampled(pa_o), $sampled(pb_o), $sampled(pc_o),
         $sampled(exp_pa), $sampled(exp_pb), $sampled(exp_pc)));

   a_rdata : assert property (@(posedge clk_sys) disable iff (reset)
      $rose(ack_o) && !we_i |-> rdata_o == exp_rdata)
      else abort_run($sformatf("error at %0t: read of %02h gave %02h, expected %02h", $time,
         $sampled(addr_i), $sampled(rdata_o), $sampled(exp_rdata)));

   // One refresh per 8 frames of 16 slots
   a_rfsh_period : assert property (@(posedge clk_sys) disable iff (reset)
      refresh_o && rfsh_seen |-> rfsh_gap == 128)
      else abort_run($sformatf("error at %0t: refresh after %0d cycles", $time,
         $sampled(rfsh_gap)));

   a_rfsh_missing : assert property (@(posedge clk_sys) disable iff (reset)
      rfsh_seen |-> rfsh_gap <= 128)
      else abort_run($sformatf("error at %0t: refresh pulse missing", $time));

   // Pause is taken only at the refresh wrap
   a_pause_sample : assert property (@(posedge clk_sys) disable iff (reset)
      refresh_o |-> pause_o == $past(pause_i))
      else abort_run($sformatf("error at %0t: pause_o does not follow pause_i", $time));

   a_pause_hold : assert property (@(posedge clk_sys) disable iff (reset)
      !refresh_o |-> $stable(pause_o))
      else abort_run($sformatf("error at %0t: pause_o moved between refreshes", $time));

   a_ack_paused : assert property (@(posedge clk_sys) disable iff (reset)
      $rose(ack_o) |-> !pause_o)
      else abort_run($sformatf("error at %0t: ack while paused", $time));

   a_ack_req : assert property (@(posedge clk_sys) disable iff (reset)
      $rose(ack_o) |-> req_i)
      else abort_run($sformatf("error at %0t: ack rose without req", $time));

   a_ack_fall : assert property (@(posedge clk_sys) disable iff (reset)
      ack_o && !req_i |=> !ack_o)
      else abort_run($sformatf("error at %0t: ack held after req fell", $time));

   a_ack_idle : assert property (@(posedge clk_sys) disable iff (reset)
      !req_i && !ack_o |=> !ack_o)
      else abort_run($sformatf("error at %0t: ack with no request pending", $time));

   // ==============================
   // Host access tasks
   // ==============================

   // Inputs move 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk_sys);
      #10;
   endtask

   task automatic start_access(input logic we, input logic [7:0] addr, input logic [7:0] data);
      busy      = 1'b1;
      exp_rdata = expected_read(addr);
      we_i      = we;
      addr_i    = addr;
      wdata_i   = data;
      req_i     = 1'b1;
   endtask

   task automatic wait_ack(input int limit);
      int n;
      n = 0;
      while (!ack_o && n < limit) begin
         next_cycle();
         n++;
      end
      if (!ack_o) abort_run("Timeout: the bridge never raised ack for the pending request");
   endtask

   task automatic finish_access();
      int n;
      // Keep req up a little past ack as back-pressure
      repeat ($urandom_range(3, 1)) next_cycle();
      req_i = 1'b0;
      n = 0;
      while (ack_o && n < 4) begin
         next_cycle();
         n++;
      end
      if (ack_o) abort_run("Timeout: ack stayed high after req was dropped");
      if (we_i) apply_write(addr_i, wdata_i);
      busy = 1'b0;
   endtask

   task automatic access(input logic we, input logic [7:0] addr, input logic [7:0] data);
      start_access(we, addr, data);
      wait_ack(40);
      finish_access();
   endtask

   // ==============================
   // Stimulus
   // ==============================

   initial begin
      int         n;
      int         pulses;
      logic [7:0] odd_addr [6];
      void'($urandom(32'hb31f1be9));
      reset     = 1'b1;
      pause_i   = 1'b0;
      req_i     = 1'b0;
      we_i      = 1'b0;
      addr_i    = '0;
      wdata_i   = '0;
      pa_in     = '1;
      pb_in     = '1;
      pc_in     = '1;
      busy      = 1'b0;
      exp_rdata = `CBM2_OPEN_BUS;
      for (int dv = 0; dv < NDEV; dv++) begin
         for (int p = 0; p < 3; p++) begin
            m_port[dv][p] = '0;
            m_dir[dv][p]  = '0;
         end
      end
      repeat (2) @(posedge clk_sys);
      #10;
      reset = 1'b0;

      // Run through two refreshes after reset so the period gets checked
      n      = 0;
      pulses = 0;
      while (pulses < 2 && n < 400) begin
         if (refresh_o) pulses++;
         next_cycle();
         n++;
      end
      if (pulses < 2) abort_run("Timeout: refresh pulses did not appear after reset");

      // Random direction and port values for every device
      for (int dv = 0; dv < NDEV; dv++) begin
         for (int p = 0; p < 3; p++) begin
            access(1'b1, reg_addr(dv, p + 3), 8'($urandom));
            access(1'b1, reg_addr(dv, p), 8'($urandom));
         end
      end

      // Port reads against random pin inputs and direction readback
      pa_in = ($bits(pa_in))'($urandom);
      pb_in = ($bits(pb_in))'($urandom);
      pc_in = ($bits(pc_in))'($urandom);
      for (int dv = 0; dv < NDEV; dv++) begin
         for (int r = 0; r < 6; r++) begin
            access(1'b0, reg_addr(dv, r), 8'h00);
         end
      end

      // Unmapped addresses and reserved selects
      odd_addr = '{8'h00, 8'h3F, 8'h50, 8'hFF, reg_addr(0, 6), reg_addr(1, 7)};
      for (int i = 0; i < 6; i++) begin
         access(1'b0, odd_addr[i], 8'h00);
         access(1'b1, odd_addr[i], 8'($urandom));
      end

      // A request started while paused stays stalled
      pause_i = 1'b1;
      n = 0;
      while (!pause_o && n < 200) begin
         next_cycle();
         n++;
      end
      if (!pause_o) abort_run("Timeout: pause_o did not rise after a refresh");
      start_access(1'b1, reg_addr(1, 3), 8'($urandom));
      repeat (300) next_cycle();
      pause_i = 1'b0;
      wait_ack(200);
      finish_access();
      access(1'b0, reg_addr(1, 3), 8'h00);

      // Ack must stay low on an idle bus
      repeat (20) next_cycle();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/cbm2_io_pkg.sv
logic/io_bus_if.sv
logic/cycle_sequencer.sv
logic/host_bus_bridge.sv
logic/triport_device.sv
logic/read_data_collector.sv
logic/cbm2_io_top.sv
tb/cbm2_io_tb.sv

// File: Bender.yml
package:
  name: cbm2_io

sources:
  - include_dirs:
      - logic
    files:
      - logic/cbm2_io_pkg.sv
      - logic/io_bus_if.sv
      - logic/cycle_sequencer.sv
      - logic/host_bus_bridge.sv
      - logic/triport_device.sv
      - logic/read_data_collector.sv
      - logic/cbm2_io_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/cbm2_io_tb.sv
